// ==== src/mult_pkg.sv ====
package mult_pkg;

    localparam int OPERAND_W   = 16;
    localparam int PRODUCT_W   = 2 * OPERAND_W;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_ADDR_W = 5;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    typedef logic [OPERAND_W-1:0]   operand_t;
    typedef logic [PRODUCT_W-1:0]   product_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
    typedef logic [1:0]             axil_resp_t;

    // Register map, byte offsets
    localparam axil_addr_t REG_CTRL      = 5'h00;
    localparam axil_addr_t REG_STATUS    = 5'h04;
    localparam axil_addr_t REG_OPERAND_A = 5'h08;
    localparam axil_addr_t REG_OPERAND_B = 5'h0C;
    localparam axil_addr_t REG_RESULT    = 5'h10;

    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    localparam axil_resp_t RESP_OKAY = 2'b00;

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

    // Controller to datapath
    typedef struct packed {
        logic load;
        logic shift;
        logic acc_add;
    } mult_ctrl_t;

    // Datapath to controller
    typedef struct packed {
        logic a_lsb;
        logic finish;
    } dp_status_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        CALC
    } ctrl_state_e;

endpackage

// ==== src/mult_controller.sv ====
module mult_controller
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  mult_pkg::dp_status_t   dp_status,
    output mult_pkg::mult_ctrl_t   ctrl,
    output logic                   busy,
    output logic                   done
);

    mult_pkg::ctrl_state_e state;
    mult_pkg::ctrl_state_e state_next;

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            state <= mult_pkg::IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            mult_pkg::IDLE:
            begin
                if (start)
                begin
                    state_next = mult_pkg::LOAD;
                end
            end
            mult_pkg::LOAD:
            begin
                state_next = mult_pkg::CALC;
            end
            mult_pkg::CALC:
            begin
                // No set bits left above the current one
                if (dp_status.finish)
                begin
                    state_next = mult_pkg::IDLE;
                end
            end
            default:
            begin
                state_next = mult_pkg::IDLE;
            end
        endcase
    end

    always_comb
    begin
        ctrl = '0;
        busy = 1'b0;
        done = 1'b0;
        case (state)
            mult_pkg::LOAD:
            begin
                ctrl.load = 1'b1;
                busy      = 1'b1;
            end
            mult_pkg::CALC:
            begin
                ctrl.shift   = 1'b1;
                ctrl.acc_add = dp_status.a_lsb;
                busy         = 1'b1;
                done         = dp_status.finish;
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== src/mult_datapath.sv ====
module mult_datapath
(
    input  logic                   clk,
    input  logic                   reset,
    input  mult_pkg::mult_ctrl_t   ctrl,
    input  mult_pkg::operand_t     operand_a,
    input  mult_pkg::operand_t     operand_b,
    output mult_pkg::dp_status_t   dp_status,
    output mult_pkg::product_t     product
);

    // Multiplier shifts right, multiplicand shifts left
    mult_pkg::operand_t mplier_q;
    mult_pkg::product_t mcand_q;
    mult_pkg::product_t acc_q;

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            mplier_q <= '0;
            mcand_q  <= '0;
        end
        else if (ctrl.load)
        begin
            mplier_q <= operand_a;
            mcand_q  <= mult_pkg::PRODUCT_W'(operand_b);
        end
        else if (ctrl.shift)
        begin
            mplier_q <= mplier_q >> 1;
            mcand_q  <= mcand_q << 1;
        end
    end

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            acc_q <= '0;
        end
        else if (ctrl.load)
        begin
            acc_q <= '0;
        end
        else if (ctrl.acc_add)
        begin
            acc_q <= acc_q + mcand_q;
        end
    end

    // Current bit is the last one once everything above it is clear,
    // so the loop runs highest-set-bit plus one cycles
    always_comb
    begin
        dp_status.a_lsb  = mplier_q[0];
        dp_status.finish = (mplier_q[mult_pkg::OPERAND_W-1:1] == '0);
    end

    assign product = acc_q;

endmodule

// ==== src/mult_axil_regs.sv ====
module mult_axil_regs
(
    input  logic                   clk,
    input  logic                   reset,
    input  mult_pkg::axil_req_t    axil_req,
    output mult_pkg::axil_rsp_t    axil_rsp,
    input  logic                   busy,
    input  logic                   done,
    input  mult_pkg::product_t     product,
    output logic                   start,
    output mult_pkg::operand_t     operand_a,
    output mult_pkg::operand_t     operand_b
);

    logic                 wr_fire;
    logic                 rd_fire;
    logic                 start_req;
    logic                 bvalid_q;
    logic                 rvalid_q;
    mult_pkg::axil_data_t rdata_q;
    mult_pkg::axil_data_t rdata_next;
    mult_pkg::operand_t   operand_a_q;
    mult_pkg::operand_t   operand_b_q;
    mult_pkg::product_t   result_q;
    logic                 done_q;
    logic                 done_sticky;

    // One transaction per channel, so a pending response blocks the next
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_fire = axil_req.arvalid && !rvalid_q;

    assign start_req = wr_fire
                    && (axil_req.awaddr == mult_pkg::REG_CTRL)
                    && axil_req.wdata[mult_pkg::CTRL_START_BIT]
                    && !busy;

    always_comb
    begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = mult_pkg::RESP_OKAY;
        axil_rsp.arready = !rvalid_q;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = mult_pkg::RESP_OKAY;
    end

    // Write response
    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            bvalid_q <= 1'b0;
        end
        else if (wr_fire)
        begin
            bvalid_q <= 1'b1;
        end
        else if (axil_req.bready)
        begin
            bvalid_q <= 1'b0;
        end
    end

    // Operand registers, wstrb ignored
    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            operand_a_q <= '0;
            operand_b_q <= '0;
        end
        else if (wr_fire)
        begin
            if (axil_req.awaddr == mult_pkg::REG_OPERAND_A)
            begin
                operand_a_q <= axil_req.wdata[mult_pkg::OPERAND_W-1:0];
            end
            if (axil_req.awaddr == mult_pkg::REG_OPERAND_B)
            begin
                operand_b_q <= axil_req.wdata[mult_pkg::OPERAND_W-1:0];
            end
        end
    end

    assign operand_a = operand_a_q;
    assign operand_b = operand_b_q;

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            start <= 1'b0;
        end
        else
        begin
            start <= start_req;
        end
    end

    // Accumulator settles one edge after the done pulse
    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            done_q      <= 1'b0;
            done_sticky <= 1'b0;
            result_q    <= '0;
        end
        else
        begin
            done_q <= done;
            if (done_q)
            begin
                result_q <= product;
            end
            // New start wins over a finishing one
            if (start_req)
            begin
                done_sticky <= 1'b0;
            end
            else if (done)
            begin
                done_sticky <= 1'b1;
            end
        end
    end

    always_comb
    begin
        rdata_next = '0;
        case (axil_req.araddr)
            mult_pkg::REG_STATUS:
            begin
                rdata_next[mult_pkg::STATUS_BUSY_BIT] = busy || start;
                rdata_next[mult_pkg::STATUS_DONE_BIT] = done_sticky;
            end
            mult_pkg::REG_OPERAND_A:
            begin
                rdata_next = mult_pkg::AXIL_DATA_W'(operand_a_q);
            end
            mult_pkg::REG_OPERAND_B:
            begin
                rdata_next = mult_pkg::AXIL_DATA_W'(operand_b_q);
            end
            mult_pkg::REG_RESULT:
            begin
                rdata_next = mult_pkg::AXIL_DATA_W'(result_q);
            end
            default:
            begin
                rdata_next = '0;
            end
        endcase
    end

    // Read response held until rready
    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
        end
        else if (rd_fire)
        begin
            rvalid_q <= 1'b1;
            rdata_q  <= rdata_next;
        end
        else if (axil_req.rready)
        begin
            rvalid_q <= 1'b0;
        end
    end

endmodule

// ==== src/mult_top.sv ====
module mult_top
(
    input  logic                  clk,
    input  logic                  reset,
    input  mult_pkg::axil_req_t   axil_req,
    output mult_pkg::axil_rsp_t   axil_rsp
);

    logic                 start;
    logic                 busy;
    logic                 done;
    mult_pkg::operand_t   operand_a;
    mult_pkg::operand_t   operand_b;
    mult_pkg::product_t   product;
    mult_pkg::mult_ctrl_t ctrl;
    mult_pkg::dp_status_t dp_status;

    mult_axil_regs u_regs
    (
        .clk       (clk),
        .reset     (reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .busy      (busy),
        .done      (done),
        .product   (product),
        .start     (start),
        .operand_a (operand_a),
        .operand_b (operand_b)
    );

    mult_controller u_controller
    (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .dp_status (dp_status),
        .ctrl      (ctrl),
        .busy      (busy),
        .done      (done)
    );

    mult_datapath u_datapath
    (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .dp_status (dp_status),
        .product   (product)
    );

endmodule

// ==== dv/mult_props.sv ====
module mult_props
(
    input logic                  clk,
    input logic                  reset,
    input logic                  start,
    input logic                  busy,
    input logic                  done,
    input mult_pkg::mult_ctrl_t  ctrl,
    input mult_pkg::ctrl_state_e state
);

    int assert_errors = 0;
    int busy_len;

    // Busy cycles before the current one
    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            busy_len <= 0;
        end
        else if (busy)
        begin
            busy_len <= busy_len + 1;
        end
        else
        begin
            busy_len <= 0;
        end
    end

    done_single: assert property (@(posedge clk) disable iff (!reset) done |=> !done)
    else
    begin
        assert_errors++;
        $error("done high two cycles in a row");
    end

    load_after_start: assert property (@(posedge clk) disable iff (!reset)
                                       ctrl.load |-> $past(start))
    else
    begin
        assert_errors++;
        $error("load without a start in the previous cycle");
    end

    idle_not_busy: assert property (@(posedge clk) disable iff (!reset)
                                    (state == mult_pkg::IDLE) |-> !busy)
    else
    begin
        assert_errors++;
        $error("busy high in IDLE");
    end

    busy_bounded: assert property (@(posedge clk) disable iff (!reset)
                                   busy |-> (busy_len < 17))
    else
    begin
        assert_errors++;
        $error("busy longer than 17 cycles");
    end

endmodule

bind mult_controller mult_props u_props
(
    .clk   (clk),
    .reset (reset),
    .start (start),
    .busy  (busy),
    .done  (done),
    .ctrl  (ctrl),
    .state (state)
);

// ==== dv/mult_checker.sv ====
module mult_checker
(
    input  logic                clk,
    input  logic                reset,
    input  mult_pkg::axil_req_t axil_req,
    input  mult_pkg::axil_rsp_t axil_rsp,
    input  string               test_name,
    output int                  errors,
    output int                  checks
);

    mult_pkg::operand_t   a_model;
    mult_pkg::operand_t   b_model;
    mult_pkg::product_t   result_model;
    mult_pkg::product_t   pending_product;
    logic                 calc_busy;
    logic                 done_seen;
    mult_pkg::axil_addr_t rd_addr;
    logic                 hold_valid;
    mult_pkg::axil_data_t hold_data;
    int                   b_pending;
    int                   err_count = 0;
    int                   chk_count = 0;

    assign errors = err_count;
    assign checks = chk_count;

    task automatic compare(input string what, input mult_pkg::axil_data_t exp,
                           input mult_pkg::axil_data_t act);
        chk_count++;
        if (exp !== act)
        begin
            err_count++;
            $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
        end
    endtask

    task automatic report(input string msg);
        err_count++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic check_read(input mult_pkg::axil_addr_t addr, input mult_pkg::axil_data_t data);
        mult_pkg::axil_data_t exp;
        exp = '0;
        case (addr)
            mult_pkg::REG_STATUS:
            begin
                if (!calc_busy)
                begin
                    exp[mult_pkg::STATUS_DONE_BIT] = done_seen;
                    compare("STATUS", exp, data);
                end
                else if (data == 32'h2)
                begin
                    // Finished, the result register now holds the product
                    chk_count++;
                    calc_busy    = 1'b0;
                    done_seen    = 1'b1;
                    result_model = pending_product;
                end
                else
                begin
                    compare("STATUS", 32'h1, data);
                end
            end
            mult_pkg::REG_RESULT:
            begin
                if (calc_busy && data == pending_product)
                begin
                    chk_count++;
                end
                else
                begin
                    compare("RESULT", result_model, data);
                end
            end
            mult_pkg::REG_OPERAND_A:
            begin
                compare("OPERAND_A", mult_pkg::axil_data_t'(a_model), data);
            end
            mult_pkg::REG_OPERAND_B:
            begin
                compare("OPERAND_B", mult_pkg::axil_data_t'(b_model), data);
            end
            default:
            begin
                compare("unmapped read", exp, data);
            end
        endcase
    endtask

    always @(posedge clk)
    begin
        if (!reset)
        begin
            a_model      = '0;
            b_model      = '0;
            result_model = '0;
            calc_busy    = 1'b0;
            done_seen    = 1'b0;
            hold_valid   = 1'b0;
            b_pending    = 0;
        end
        else
        begin
            if (axil_req.awvalid && axil_rsp.awready && axil_req.wvalid && axil_rsp.wready)
            begin
                if (b_pending != 0)
                begin
                    report("write accepted while its response was still pending");
                end
                b_pending++;
                case (axil_req.awaddr)
                    mult_pkg::REG_OPERAND_A:
                    begin
                        a_model = axil_req.wdata[mult_pkg::OPERAND_W-1:0];
                    end
                    mult_pkg::REG_OPERAND_B:
                    begin
                        b_model = axil_req.wdata[mult_pkg::OPERAND_W-1:0];
                    end
                    mult_pkg::REG_CTRL:
                    begin
                        // A start while busy is dropped
                        if (axil_req.wdata[mult_pkg::CTRL_START_BIT] && !calc_busy)
                        begin
                            calc_busy       = 1'b1;
                            done_seen       = 1'b0;
                            pending_product = mult_pkg::product_t'(a_model)
                                            * mult_pkg::product_t'(b_model);
                        end
                    end
                    default:
                    begin
                    end
                endcase
            end
            if (axil_rsp.bvalid && axil_req.bready)
            begin
                compare("BRESP", 32'h0, mult_pkg::axil_data_t'(axil_rsp.bresp));
                if (b_pending == 0)
                begin
                    report("write response without an accepted write");
                end
                else
                begin
                    b_pending--;
                end
            end
            if (axil_req.arvalid && axil_rsp.arready)
            begin
                rd_addr = axil_req.araddr;
            end
            if (axil_rsp.rvalid)
            begin
                if (hold_valid && axil_rsp.rdata !== hold_data)
                begin
                    report("rdata changed while the read response was stalled");
                end
                hold_valid = !axil_req.rready;
                hold_data  = axil_rsp.rdata;
                if (axil_req.rready)
                begin
                    compare("RRESP", 32'h0, mult_pkg::axil_data_t'(axil_rsp.rresp));
                    check_read(rd_addr, axil_rsp.rdata);
                end
            end
            else if (hold_valid)
            begin
                report("rvalid dropped before rready");
                hold_valid = 1'b0;
            end
        end
    end

endmodule

// ==== dv/mult_tb.sv ====
module mult_tb;

    localparam int NUM_PAIRS     = 150;
    localparam int NUM_READBACK  = 20;
    localparam int NUM_STALL_OPS = 40;
    // Three writes, polls across up to 19 busy cycles, one result read
    localparam int TXN_PER_CALC  = 12;
    localparam int TOTAL_TXN     = 4 + (NUM_PAIRS + NUM_READBACK + 4) * TXN_PER_CALC
                                 + 2 * NUM_STALL_OPS;
    localparam int TIMEOUT_CYCLES = TOTAL_TXN * 60;

    logic                clk = 1'b0;
    logic                reset;
    mult_pkg::axil_req_t axil_req;
    mult_pkg::axil_rsp_t axil_rsp;
    string               test_name = "none";
    int                  chk_errors;
    int                  chk_count;
    int                  stall_max = 4;
    int                  cycle_count = 0;
    int                  err_base = 0;
    int                  tests_run = 0;
    int                  tests_bad = 0;

    always #5 clk = ~clk;

    mult_top u_dut
    (
        .clk      (clk),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    mult_checker u_checker
    (
        .clk       (clk),
        .reset     (reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .test_name (test_name),
        .errors    (chk_errors),
        .checks    (chk_count)
    );

    function automatic int total_errors();
        return chk_errors + u_dut.u_controller.u_props.assert_errors;
    endfunction

    // Holds bready or rready low for a few cycles
    task automatic random_stall();
        int n;
        n = $urandom % (stall_max + 1);
        repeat (n) @(negedge clk);
    endtask

    task automatic axi_write(input mult_pkg::axil_addr_t addr, input mult_pkg::axil_data_t data);
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = '1;
        do @(posedge clk); while (!axil_rsp.awready);
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        random_stall();
        axil_req.bready = 1'b1;
        do @(posedge clk); while (!axil_rsp.bvalid);
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    // Second write waits on the bus while the first response is held off
    task automatic write_while_pending(input mult_pkg::axil_addr_t addr0,
                                       input mult_pkg::axil_data_t data0,
                                       input mult_pkg::axil_addr_t addr1,
                                       input mult_pkg::axil_data_t data1);
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr0;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data0;
        axil_req.wstrb   = '1;
        do @(posedge clk); while (!axil_rsp.awready);
        @(negedge clk);
        axil_req.awaddr = addr1;
        axil_req.wdata  = data1;
        random_stall();
        axil_req.bready = 1'b1;
        do @(posedge clk); while (!axil_rsp.bvalid);
        @(negedge clk);
        axil_req.bready = 1'b0;
        do @(posedge clk); while (!axil_rsp.awready);
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        random_stall();
        axil_req.bready = 1'b1;
        do @(posedge clk); while (!axil_rsp.bvalid);
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(input mult_pkg::axil_addr_t addr, output mult_pkg::axil_data_t data);
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        do @(posedge clk); while (!axil_rsp.arready);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        random_stall();
        axil_req.rready = 1'b1;
        do @(posedge clk); while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic wait_done();
        mult_pkg::axil_data_t status;
        status = '0;
        while (!status[mult_pkg::STATUS_DONE_BIT])
        begin
            axi_read(mult_pkg::REG_STATUS, status);
        end
    endtask

    task automatic run_product(input mult_pkg::operand_t a, input mult_pkg::operand_t b);
        mult_pkg::axil_data_t data;
        axi_write(mult_pkg::REG_OPERAND_A, mult_pkg::axil_data_t'(a));
        axi_write(mult_pkg::REG_OPERAND_B, mult_pkg::axil_data_t'(b));
        axi_write(mult_pkg::REG_CTRL, 32'h1);
        wait_done();
        axi_read(mult_pkg::REG_RESULT, data);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_base  = total_errors();
    endtask

    task automatic end_test();
        int n;
        n = total_errors() - err_base;
        tests_run++;
        if (n == 0)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d errors", test_name, n);
        end
    endtask

    initial
    begin
        mult_pkg::operand_t   a;
        mult_pkg::operand_t   b;
        mult_pkg::axil_data_t data;
        mult_pkg::axil_addr_t addr;
        int                   op;
        void'($urandom(32'h89e01ba3));
        reset    = 1'b0;
        axil_req = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        begin_test("reset_values");
        axi_read(mult_pkg::REG_STATUS, data);
        axi_read(mult_pkg::REG_RESULT, data);
        axi_read(mult_pkg::REG_OPERAND_A, data);
        axi_read(mult_pkg::REG_OPERAND_B, data);
        end_test();

        begin_test("random_products");
        for (int i = 0; i < NUM_PAIRS; i++)
        begin
            a = mult_pkg::operand_t'($urandom);
            b = mult_pkg::operand_t'($urandom);
            run_product(a, b);
        end
        end_test();

        // Odd rounds write the operands while a calculation runs
        begin_test("operand_readback");
        for (int i = 0; i < NUM_READBACK; i++)
        begin
            if (i % 2 == 1)
            begin
                a = mult_pkg::operand_t'($urandom) | 16'h8000;
                axi_write(mult_pkg::REG_OPERAND_A, mult_pkg::axil_data_t'(a));
                axi_write(mult_pkg::REG_CTRL, 32'h1);
            end
            axi_write(mult_pkg::REG_OPERAND_A, $urandom);
            axi_write(mult_pkg::REG_OPERAND_B, $urandom);
            axi_read(mult_pkg::REG_OPERAND_A, data);
            axi_read(mult_pkg::REG_OPERAND_B, data);
            if (i % 2 == 1)
            begin
                wait_done();
            end
        end
        end_test();

        // No stalls so the second start lands inside the 16 CALC cycles
        begin_test("writes_during_calc");
        stall_max = 0;
        a = mult_pkg::operand_t'($urandom) | 16'h8000;
        b = mult_pkg::operand_t'($urandom);
        axi_write(mult_pkg::REG_OPERAND_A, mult_pkg::axil_data_t'(a));
        axi_write(mult_pkg::REG_OPERAND_B, mult_pkg::axil_data_t'(b));
        axi_write(mult_pkg::REG_CTRL, 32'h1);
        axi_write(mult_pkg::REG_OPERAND_A, $urandom);
        axi_write(mult_pkg::REG_CTRL, 32'h1);
        stall_max = 4;
        wait_done();
        axi_read(mult_pkg::REG_RESULT, data);
        axi_read(mult_pkg::REG_STATUS, data);
        end_test();

        begin_test("edge_operands");
        run_product(16'h0000, mult_pkg::operand_t'($urandom));
        run_product(mult_pkg::operand_t'($urandom), 16'h0000);
        run_product(16'hFFFF, 16'hFFFF);
        end_test();

        begin_test("back_pressure");
        for (int i = 0; i < NUM_STALL_OPS; i++)
        begin
            op = $urandom % 4;
            if (op == 0)
            begin
                axi_write(mult_pkg::REG_OPERAND_A, $urandom);
            end
            else if (op == 1)
            begin
                axi_write(mult_pkg::REG_OPERAND_B, $urandom);
            end
            else if (op == 2)
            begin
                addr = mult_pkg::axil_addr_t'(($urandom % 6) * 4);
                axi_read(addr, data);
            end
            else
            begin
                write_while_pending(mult_pkg::REG_OPERAND_A, $urandom,
                                    mult_pkg::REG_OPERAND_B, $urandom);
            end
        end
        end_test();

        $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, chk_count, total_errors());
        if (tests_bad == 0 && total_errors() == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

endmodule

// ==== shift_add_mult.f ====
src/mult_pkg.sv
src/mult_controller.sv
src/mult_datapath.sv
src/mult_axil_regs.sv
src/mult_top.sv
dv/mult_props.sv
dv/mult_checker.sv
dv/mult_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the multiplier testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module mult_tb -f shift_add_mult.f -o mult_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/mult_sim +verilator+error+limit+10000)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^Test passed$"; then
    exit 0
fi
echo "Pass message not found"
exit 1
